//--- bench/dcache_properties.sv
// Handshake checks bound into dcache_top; assumes every W burst has exactly two beats
`timescale 1ns/1ps

module dcache_properties import dcache_pkg::*; (
    input logic      clk,
    input logic      rst,
    input cpu_req_t  cpu_req,
    input logic      req_ready,
    input logic      rsp_valid,
    input axi_addr_t ar,
    input logic      arvalid,
    input logic      arready,
    input axi_addr_t aw,
    input logic      awvalid,
    input logic      awready,
    input axi_w_t    w,
    input logic      wvalid,
    input logic      wready
);

    int   fail_count = 0;     // Failed assertions so far
    logic w_second_q;         // Next W beat closes the burst
    logic pending_q;          // Request accepted, response still owed

    always_ff @(posedge clk) begin
        if (rst) begin
            w_second_q <= 1'b0;
        end else if (wvalid && wready) begin
            w_second_q <= ~w_second_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending_q <= 1'b0;
        end else if (req_ready && (cpu_req.op != OP_NONE)) begin
            pending_q <= 1'b1;
        end else if (rsp_valid) begin
            pending_q <= 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // Valid held with stable payload until ready
    // ------------------------------------------------------------------------
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(ar))
        else begin
            fail_count++;
            $error("AR valid or payload changed before arready");
        end

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(aw))
        else begin
            fail_count++;
            $error("AW valid or payload changed before awready");
        end

    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(w))
        else begin
            fail_count++;
            $error("W valid or payload changed before wready");
        end

    // Response only for an accepted request
    rsp_pending: assert property (@(posedge clk) disable iff (rst)
        rsp_valid |-> pending_q)
        else begin
            fail_count++;
            $error("rsp_valid without an outstanding request");
        end

    // No new request taken until the response, so no rsp_valid with req_ready
    busy_excl: assert property (@(posedge clk) disable iff (rst)
        pending_q |-> !req_ready)
        else begin
            fail_count++;
            $error("req_ready raised while a request is outstanding");
        end

    wlast_pos: assert property (@(posedge clk) disable iff (rst)
        wvalid |-> (w.last == w_second_q))
        else begin
            fail_count++;
            $error("wlast not on the second W beat");
        end

endmodule

bind dcache_top dcache_properties u_props (.*);

//--- bench/dcache_tb.sv
// Random-latency AXI memory with whole-address fill; one CPU request at a time, seed 78
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_tb import dcache_pkg::*; ;

    logic      clk;
    logic      rst;
    cpu_req_t  cpu_req;
    logic      req_ready, rsp_valid;
    word_t     rsp_rdata;
    axi_addr_t ar, aw;
    axi_w_t    w;
    axi_r_t    r;
    logic      arvalid, arready, awvalid, awready, wvalid, wready;
    logic      rvalid, rready, bvalid, bready;

    // -----------------------------------------------------------------------
    // Memory model and reference state
    // -----------------------------------------------------------------------
    logic [7:0] mem    [addr_t];    // Bytes written back by the cache
    logic [7:0] shadow [addr_t];    // Bytes written by the CPU
    addr_t      rd_ptr, wr_addr, last_ar, last_aw;
    int         rd_left, w_cnt, ar_count, aw_count;
    logic       aw_seen;            // AW taken, waiting for both W beats
    word_t      w_beats [2];
    tag_t       base;
    word_t      rdata;
    int         lat, n_ar, n_aw;
    addr_t      a;

    dcache_top uut (.*);

    always #50 clk = ~clk;

    // Fill byte folds every address byte
    function automatic logic [7:0] fill_byte(addr_t addr);
        return addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ addr[31:24] ^ 8'h5A;
    endfunction

    function automatic word_t mem_word(addr_t addr);
        word_t v;
        addr_t ba;
        for (int b = 0; b < 4; b++) begin
            ba = addr_t'(addr + b);
            v[b*8 +: 8] = mem.exists(ba) ? mem[ba] : fill_byte(ba);
        end
        return v;
    endfunction

    // Expected word: last CPU write per byte, else the fill pattern
    function automatic word_t ref_word(addr_t addr);
        word_t v;
        addr_t ba;
        for (int b = 0; b < 4; b++) begin
            ba = addr_t'({addr[31:2], 2'b00} + b);
            v[b*8 +: 8] = shadow.exists(ba) ? shadow[ba] : fill_byte(ba);
        end
        return v;
    endfunction

    function automatic addr_t make_addr(tag_t t, index_t i, logic hi);
        return {t, i, hi, 2'b00};
    endfunction

    // -----------------------------------------------------------------------
    // Error reporting and compare tasks
    // -----------------------------------------------------------------------
    task automatic stop_run(string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_word(word_t got, word_t exp, string msg);
        if (got !== exp)
            stop_run($sformatf("CHECK FAILED at %0t: %s, got %h expected %h",
                               $time, msg, got, exp));
    endtask

    task automatic check_addr(addr_t got, addr_t exp, string msg);
        if (got !== exp)
            stop_run($sformatf("CHECK FAILED at %0t: %s, got %h expected %h",
                               $time, msg, got, exp));
    endtask

    task automatic check_bit(logic got, logic exp, string msg);
        if (got !== exp)
            stop_run($sformatf("CHECK FAILED at %0t: %s, got %b expected %b",
                               $time, msg, got, exp));
    endtask

    // Bound checker counts failed assertions
    always @(posedge clk) begin
        if (uut.u_props.fail_count != 0) begin
            stop_run("A handshake assertion failed during the run");
        end
    end

    // -----------------------------------------------------------------------
    // CPU requests
    // -----------------------------------------------------------------------
    task automatic do_req(cpu_op_e op, addr_t addr, word_t wdata, strb_t strb);
        int n;
        cpu_req <= '{op: op, addr: addr, wdata: wdata, wstrb: strb};
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > 200) stop_run("Timeout: request was never accepted");
        end while (!req_ready);
        cpu_req <= '0;                          // Taken on this edge
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
            if (lat > 500) stop_run("Timeout: no rsp_valid after request");
        end while (!rsp_valid);
        rdata = rsp_rdata;
    endtask

    task automatic write_word(addr_t addr, word_t data, strb_t strb);
        do_req(OP_WRITE, addr, data, strb);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) shadow[addr_t'({addr[31:2], 2'b00} + b)] = data[b*8 +: 8];
        end
    endtask

    task automatic read_expect(addr_t addr);
        do_req(OP_READ, addr, '0, '0);
        check_word(rdata, ref_word(addr), $sformatf("read data at %h", addr));
    endtask

    // -----------------------------------------------------------------------
    // AXI memory with random ready and valid delays
    // -----------------------------------------------------------------------
    always @(posedge clk) begin
        if (rst) begin
            arready  <= 1'b0;
            awready  <= 1'b0;
            wready   <= 1'b0;
            rvalid   <= 1'b0;
            bvalid   <= 1'b0;
            ar_count <= 0;
            aw_count <= 0;
            rd_ptr   = '0;
            rd_left  = 0;
            w_cnt    = 0;
            aw_seen  = 1'b0;
        end else begin
            arready <= ($urandom_range(3) != 0);
            awready <= ($urandom_range(3) != 0);
            wready  <= ($urandom_range(3) != 0);
            if (rvalid && rready) begin
                rd_ptr  = rd_ptr + 32'd4;
                rd_left = rd_left - 1;
            end
            if (arvalid && arready) begin
                check_bit(ar.len == 8'd1 && ar.size == 3'd2 && ar.burst == 2'b01, 1'b1,
                          "AR is a 2-beat INCR burst of 4-byte beats");
                rd_ptr   = ar.addr;
                rd_left  = 2;
                last_ar  <= ar.addr;
                ar_count <= ar_count + 1;
            end
            if (!rvalid || rready) begin        // No stalled beat to hold
                rvalid <= (rd_left != 0) && ($urandom_range(3) != 0);
                r      <= '{data: mem_word(rd_ptr), resp: 2'b00, last: (rd_left == 1)};
            end
            if (awvalid && awready) begin
                check_bit(aw.len == 8'd1 && aw.size == 3'd2 && aw.burst == 2'b01, 1'b1,
                          "AW is a 2-beat INCR burst of 4-byte beats");
                wr_addr  = aw.addr;
                aw_seen  = 1'b1;
                last_aw  <= aw.addr;
                aw_count <= aw_count + 1;
            end
            if (wvalid && wready) begin
                check_bit(w.strb == 4'hF, 1'b1, "W beat with all strobes set");
                w_beats[w_cnt] = w.data;
                w_cnt++;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end else if (aw_seen && w_cnt == 2 && $urandom_range(1) == 0) begin
                for (int i = 0; i < 2; i++) begin
                    for (int b = 0; b < 4; b++) begin
                        mem[addr_t'(wr_addr + 4*i + b)] = w_beats[i][b*8 +: 8];
                    end
                end
                aw_seen = 1'b0;
                w_cnt   = 0;
                bvalid  <= 1'b1;
            end
        end
    end

    // -----------------------------------------------------------------------
    // Stimulus
    // -----------------------------------------------------------------------
    initial begin
        clk     = 1'b0;
        rst     = 1'b1;
        cpu_req = '0;
        arready = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        rvalid  = 1'b0;
        bvalid  = 1'b0;
        r       = '0;
        void'($urandom(78));
        base = tag_t'($urandom);
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        check_bit(arvalid, 1'b0, "arvalid after reset");
        check_bit(awvalid, 1'b0, "awvalid after reset");
        check_bit(wvalid, 1'b0, "wvalid after reset");
        check_bit(rsp_valid, 1'b0, "rsp_valid after reset");
        check_bit(req_ready, 1'b1, "req_ready after reset");

        // Read miss, then a hit in the same line
        n_ar = ar_count;
        read_expect(make_addr(base, 3'd1, 1'b1));
        check_bit(ar_count == n_ar + 1, 1'b1, "one AR for a read miss");
        check_addr(last_ar, make_addr(base, 3'd1, 1'b0), "AR line address");
        read_expect(make_addr(base, 3'd1, 1'b0));
        check_bit(lat == 1 && ar_count == n_ar + 1, 1'b1, "hit in one cycle without AR");

        a = make_addr(base, 3'd1, 1'b1);
        write_word(a, $urandom, strb_t'($urandom));
        read_expect(a);

        // Two dirty lines in set 2, third tag evicts the older one
        write_word(make_addr(base, 3'd2, 1'b0), $urandom, 4'hF);
        write_word(make_addr(base + 26'd1, 3'd2, 1'b1), $urandom, 4'h3);
        n_aw = aw_count;
        read_expect(make_addr(base + 26'd2, 3'd2, 1'b0));
        check_bit(aw_count == n_aw + 1, 1'b1, "one AW for a dirty victim");
        a = make_addr(base, 3'd2, 1'b0);
        check_addr(last_aw, a, "AW address of the LRU line");
        check_word(w_beats[0], ref_word(a), "first W beat");
        check_word(w_beats[1], ref_word(a + 32'd4), "second W beat");

        // A, B, A, then C must evict B
        read_expect(make_addr(base, 3'd3, 1'b0));
        read_expect(make_addr(base + 26'd1, 3'd3, 1'b0));
        read_expect(make_addr(base, 3'd3, 1'b1));
        read_expect(make_addr(base + 26'd2, 3'd3, 1'b0));
        n_ar = ar_count;
        read_expect(make_addr(base, 3'd3, 1'b0));
        check_bit(ar_count == n_ar, 1'b1, "tag A still cached after C");

        for (int k = 0; k < 200; k++) begin
            a = make_addr(base + 26'($urandom_range(3)), 3'(4 + $urandom_range(3)),
                          1'($urandom_range(1)));
            if ($urandom_range(1) == 1) write_word(a, $urandom, strb_t'($urandom));
            else read_expect(a);
        end

        if (uut.u_props.fail_count == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            stop_run("A handshake assertion failed during the run");
        end
    end

endmodule

//--- dcache_top.f
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_array.sv
hw/dcache_ctrl.sv
hw/dcache_bus.sv
hw/dcache_top.sv
bench/dcache_properties.sv
bench/dcache_tb.sv

//--- hw/dcache_array.sv
// Tag, state and data storage for 2 ways x 8 sets; answers only for the latched request
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_array import dcache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  ctrl_state_e state,
    input  cpu_req_t    req_q,
    output lookup_t     look,
    output line_t       wb_line,
    input  logic        r_beat_valid,
    input  word_t       r_beat,
    input  logic        r_beat_idx
);

    // -----------------------------------------------------------------------
    // Storage
    // -----------------------------------------------------------------------
    line_t data_q  [2**`DC_INDEX_W][2];
    tag_t  tag_q   [2**`DC_INDEX_W][2];
    logic  valid_q [2**`DC_INDEX_W][2];
    logic  dirty_q [2**`DC_INDEX_W][2];
    logic  lru_q   [2**`DC_INDEX_W];       // Way to evict next

    index_t idx;
    tag_t   tag;
    logic   word_sel;                      // Low or high word of the line
    logic   hit0;
    logic   hit1;
    logic   hit;
    logic   hit_way;
    logic   victim_way;
    logic   sel_way;
    word_t  old_word;
    word_t  merged_word;
    logic   do_hit;
    logic   do_refill;

    // Address split
    assign idx      = req_q.addr[`DC_OFFSET_W +: `DC_INDEX_W];
    assign tag      = req_q.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign word_sel = req_q.addr[`DC_OFFSET_W-1];

    // -----------------------------------------------------------------------
    // Hit detection and way choice
    // -----------------------------------------------------------------------
    assign hit0 = valid_q[idx][0] && (tag_q[idx][0] == tag);
    assign hit1 = valid_q[idx][1] && (tag_q[idx][1] == tag);
    assign hit  = hit0 || hit1;

    assign hit_way    = hit1;
    assign victim_way = lru_q[idx];
    assign sel_way    = hit ? hit_way : victim_way;

    assign old_word = data_q[idx][sel_way][{word_sel, 5'd0} +: `DC_WORD_W];

    // Strobed bytes from the CPU, the rest kept from the line
    always_comb begin
        for (int b = 0; b < `DC_STRB_W; b++) begin
            merged_word[b*8 +: 8] = req_q.wstrb[b] ? req_q.wdata[b*8 +: 8]
                                                   : old_word[b*8 +: 8];
        end
    end

    always_comb begin
        look.hit          = hit;
        look.victim_dirty = valid_q[idx][victim_way] && dirty_q[idx][victim_way];
        look.victim_tag   = tag_q[idx][victim_way];
        look.rdata        = old_word;
    end

    assign wb_line = data_q[idx][victim_way];   // Held steady through write-back

    assign do_hit    = (state == ST_LOOKUP) && hit;
    assign do_refill = (state == ST_REFILL) && r_beat_valid;

    // -----------------------------------------------------------------------
    // Line state and LRU
    // -----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < 2**`DC_INDEX_W; s++) begin
                lru_q[s]      <= 1'b0;
                valid_q[s][0] <= 1'b0;
                valid_q[s][1] <= 1'b0;
                dirty_q[s][0] <= 1'b0;
                dirty_q[s][1] <= 1'b0;
            end
        end else if (do_hit) begin
            lru_q[idx] <= ~hit_way;            // Other way becomes victim
            if (req_q.op == OP_WRITE) begin
                dirty_q[idx][hit_way] <= 1'b1;
            end
        end else if (do_refill && r_beat_idx) begin
            // Last beat in, line now clean and usable
            valid_q[idx][victim_way] <= 1'b1;
            dirty_q[idx][victim_way] <= 1'b0;
        end
    end

    // -----------------------------------------------------------------------
    // Data and tag writes
    // -----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (do_hit && (req_q.op == OP_WRITE)) begin
            data_q[idx][hit_way][{word_sel, 5'd0} +: `DC_WORD_W] <= merged_word;
        end
        if (do_refill) begin
            data_q[idx][victim_way][{r_beat_idx, 5'd0} +: `DC_WORD_W] <= r_beat;
            if (r_beat_idx) begin
                tag_q[idx][victim_way] <= tag;
            end
        end
    end

endmodule

//--- hw/dcache_bus.sv
// AXI4 master for 2-beat INCR line bursts only; W may be offered before AW is accepted
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_bus import dcache_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  cpu_req_t  req_q,
    input  lookup_t   look,
    input  line_t     wb_line,
    input  logic      start_read,
    input  logic      start_write,
    // AXI4 master
    output axi_addr_t ar,
    output logic      arvalid,
    input  logic      arready,
    output axi_addr_t aw,
    output logic      awvalid,
    input  logic      awready,
    output axi_w_t    w,
    output logic      wvalid,
    input  logic      wready,
    input  axi_r_t    r,
    input  logic      rvalid,
    output logic      rready,
    input  logic      bvalid,
    output logic      bready,
    // Refill beats and completion
    output logic      r_beat_valid,
    output word_t     r_beat,
    output logic      r_beat_idx,
    output logic      line_done,
    output logic      wb_done
);

    index_t     idx;
    logic       rd_open_q;             // Read burst in progress
    logic       wr_open_q;             // Write burst in progress
    logic [1:0] w_cnt_q;               // W beats already sent
    logic       r_cnt_q;               // Index of the next R beat

    assign idx = req_q.addr[`DC_OFFSET_W +: `DC_INDEX_W];

    // -----------------------------------------------------------------------
    // Address channels
    // -----------------------------------------------------------------------
    always_comb begin
        ar.addr  = {req_q.addr[`DC_ADDR_W-1 -: `DC_TAG_W], idx, {`DC_OFFSET_W{1'b0}}};
        ar.len   = 8'(`DC_BEATS - 1);
        ar.size  = 3'b010;                     // 4 bytes per beat
        ar.burst = 2'b01;                      // INCR
        aw.addr  = {look.victim_tag, idx, {`DC_OFFSET_W{1'b0}}};
        aw.len   = 8'(`DC_BEATS - 1);
        aw.size  = 3'b010;
        aw.burst = 2'b01;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            arvalid <= 1'b0;
            awvalid <= 1'b0;
        end else begin
            if (start_read) arvalid <= 1'b1;
            else if (arready) arvalid <= 1'b0;
            if (start_write) awvalid <= 1'b1;
            else if (awready) awvalid <= 1'b0;
        end
    end

    // -----------------------------------------------------------------------
    // Write data and response
    // -----------------------------------------------------------------------
    assign wvalid = wr_open_q && (w_cnt_q != 2'(`DC_BEATS));
    assign w.data = w_cnt_q[0] ? wb_line[`DC_LINE_W-1 -: `DC_WORD_W]
                               : wb_line[`DC_WORD_W-1:0];
    assign w.strb = '1;                        // Whole line always written
    assign w.last = (w_cnt_q == 2'(`DC_BEATS - 1));

    assign bready  = wr_open_q;
    assign wb_done = bvalid && bready;

    // -----------------------------------------------------------------------
    // Read data
    // -----------------------------------------------------------------------
    assign rready       = rd_open_q;
    assign r_beat_valid = rvalid && rready;
    assign r_beat       = r.data;
    assign r_beat_idx   = r_cnt_q;
    assign line_done    = r_beat_valid && r_cnt_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_open_q <= 1'b0;
            wr_open_q <= 1'b0;
            w_cnt_q   <= 2'd0;
            r_cnt_q   <= 1'b0;
        end else begin
            if (start_write) begin
                wr_open_q <= 1'b1;
                w_cnt_q   <= 2'd0;
            end else if (wb_done) begin
                wr_open_q <= 1'b0;
            end else if (wvalid && wready) begin
                w_cnt_q <= w_cnt_q + 2'd1;
            end
            if (start_read) begin
                rd_open_q <= 1'b1;
                r_cnt_q   <= 1'b0;
            end else if (line_done) begin
                rd_open_q <= 1'b0;
                r_cnt_q   <= 1'b0;
            end else if (r_beat_valid) begin
                r_cnt_q <= 1'b1;
            end
        end
    end

endmodule

//--- hw/dcache_ctrl.sv
// One CPU request in flight; the CPU must hold cpu_req stable until req_ready is seen
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    // CPU side
    input  cpu_req_t    cpu_req,
    output logic        req_ready,
    output logic        rsp_valid,
    // To array and bus master
    output cpu_req_t    req_q,
    output ctrl_state_e state,
    input  lookup_t     look,
    output logic        start_read,
    output logic        start_write,
    input  logic        line_done,
    input  logic        wb_done
);

    ctrl_state_e state_d;
    logic        take;

    // Request accepted on this edge
    assign take = (state == ST_IDLE) && (cpu_req.op != OP_NONE);

    assign req_ready = (state == ST_IDLE);
    assign rsp_valid = (state == ST_LOOKUP) && look.hit;

    // -----------------------------------------------------------------------
    // Request latch
    // -----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (take) begin
            req_q <= cpu_req;
        end
    end

    // -----------------------------------------------------------------------
    // Miss handling FSM
    // -----------------------------------------------------------------------
    always_comb begin
        state_d     = state;
        start_read  = 1'b0;
        start_write = 1'b0;
        case (state)
            ST_IDLE: begin
                if (take) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (look.hit) begin
                    state_d = ST_IDLE;         // Array updated on this edge
                end else if (look.victim_dirty) begin
                    state_d     = ST_WRITEBACK;
                    start_write = 1'b1;
                end else begin
                    state_d    = ST_REFILL;
                    start_read = 1'b1;
                end
            end
            ST_WRITEBACK: begin
                // Refill follows the B response
                if (wb_done) begin
                    state_d    = ST_REFILL;
                    start_read = 1'b1;
                end
            end
            ST_REFILL: begin
                if (line_done) begin
                    state_d = ST_LOOKUP;       // Retry now hits
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_d;
        end
    end

endmodule

//--- hw/dcache_params.svh
// Geometry fixed at 2 ways, 8 sets and 64-bit lines; the RTL is not checked for other values
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// ---------------------------------------------------------------------------
// Address and data widths
// ---------------------------------------------------------------------------
`define DC_ADDR_W    32              // Byte address
`define DC_WORD_W    32              // CPU and AXI data bus
`define DC_STRB_W    4               // One strobe per byte of a word

// ---------------------------------------------------------------------------
// Cache geometry
// ---------------------------------------------------------------------------
`define DC_INDEX_W   3               // 8 sets
`define DC_OFFSET_W  3               // 8 bytes per line

// Whatever is left of the address above index and offset
`define DC_TAG_W     26

`define DC_LINE_W    64              // Two words per line

// Refill and write-back bursts move a whole line
`define DC_BEATS     2

`endif

//--- hw/dcache_pkg.sv
// Types shared by the cache RTL and its testbench; widths come from the params header
`include "dcache_params.svh"

package dcache_pkg;

    // -----------------------------------------------------------------------
    // Plain vectors
    // -----------------------------------------------------------------------
    typedef logic [`DC_ADDR_W-1:0]  addr_t;
    typedef logic [`DC_WORD_W-1:0]  word_t;
    typedef logic [`DC_STRB_W-1:0]  strb_t;
    typedef logic [`DC_TAG_W-1:0]   tag_t;
    typedef logic [`DC_INDEX_W-1:0] index_t;
    typedef logic [`DC_LINE_W-1:0]  line_t;

    // -----------------------------------------------------------------------
    // CPU side and controller
    // -----------------------------------------------------------------------
    typedef enum logic [1:0] {OP_NONE, OP_READ, OP_WRITE} cpu_op_e;

    typedef struct packed {
        cpu_op_e op;
        addr_t   addr;
        word_t   wdata;
        strb_t   wstrb;     // Ignored for reads
    } cpu_req_t;

    typedef enum logic [1:0] {ST_IDLE, ST_LOOKUP, ST_WRITEBACK, ST_REFILL} ctrl_state_e;

    // Array answer for the latched request
    typedef struct packed {
        logic  hit;
        logic  victim_dirty;
        tag_t  victim_tag;
        word_t rdata;       // Addressed word of the hit way
    } lookup_t;

    // -----------------------------------------------------------------------
    // AXI4 channel payloads
    // -----------------------------------------------------------------------
    typedef struct packed {
        addr_t       addr;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_addr_t;

    typedef struct packed {
        word_t data;
        strb_t strb;
        logic  last;
    } axi_w_t;

    typedef struct packed {
        word_t      data;
        logic [1:0] resp;
        logic       last;
    } axi_r_t;

endpackage

//--- hw/dcache_top.sv
// Write-back data cache top; AXI IDs are not provided and the slave must use ID 0
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // CPU port
    input  cpu_req_t  cpu_req,
    output logic      req_ready,
    output logic      rsp_valid,
    output word_t     rsp_rdata,
    // AXI4 master
    output axi_addr_t ar,
    output logic      arvalid,
    input  logic      arready,
    output axi_addr_t aw,
    output logic      awvalid,
    input  logic      awready,
    output axi_w_t    w,
    output logic      wvalid,
    input  logic      wready,
    input  axi_r_t    r,
    input  logic      rvalid,
    output logic      rready,
    input  logic      bvalid,
    output logic      bready
);

    cpu_req_t    req_q;
    ctrl_state_e state;
    lookup_t     look;
    line_t       wb_line;
    logic        start_read;
    logic        start_write;
    logic        line_done;
    logic        wb_done;
    logic        r_beat_valid;
    word_t       r_beat;
    logic        r_beat_idx;

    assign rsp_rdata = look.rdata;     // Only sampled with rsp_valid

    dcache_ctrl u_ctrl (
        .clk, .rst, .cpu_req, .req_ready, .rsp_valid, .req_q, .state, .look,
        .start_read, .start_write, .line_done, .wb_done
    );

    dcache_array u_array (
        .clk, .rst, .state, .req_q, .look, .wb_line,
        .r_beat_valid, .r_beat, .r_beat_idx
    );

    dcache_bus u_bus (
        .clk, .rst, .req_q, .look, .wb_line, .start_read, .start_write,
        .ar, .arvalid, .arready, .aw, .awvalid, .awready,
        .w, .wvalid, .wready, .r, .rvalid, .rready, .bvalid, .bready,
        .r_beat_valid, .r_beat, .r_beat_idx, .line_done, .wb_done
    );

endmodule
